//--- source/uart_cfg_pkg.sv
package uart_cfg_pkg;

	// Bit period input width. Allows up to 1023 clock cycles per bit.
	localparam int unsigned CPD_W = 10;
	localparam int unsigned MIN_CPD = 4; // Shortest period the receiver can time.

	localparam int unsigned DATA_BITS = 8;
	localparam int unsigned FRAME_BITS = DATA_BITS + 2; // Start, data and one stop bit.
	localparam int unsigned BIT_IDX_W = $clog2(DATA_BITS + 1);
	localparam int unsigned FRAME_CNT_W = $clog2(FRAME_BITS);

	localparam int unsigned FIFO_DEPTH = 4;
	localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1); // Must hold the value FIFO_DEPTH.

endpackage

//--- source/uart_frame_pkg.sv
package uart_frame_pkg;

	import uart_cfg_pkg::*;

	// One data byte as written by the user and shifted out by the transmitter.
	typedef logic [DATA_BITS-1:0] uart_byte_t;

	// A received frame together with its stop-bit status.
	typedef struct packed {
		uart_byte_t data;      // Data bits, first received bit in bit 0.
		logic       frame_err; // Set when the stop bit was sampled low.
	} uart_rx_frame_t;

endpackage

//--- source/uart_fifo.sv
module uart_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     resetn,
	input  logic     push_i,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output payload_t head_o,
	output logic     empty_o,
	output logic     full_o
);
	import uart_cfg_pkg::*;

	payload_t              mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr_q;
	logic [FIFO_PTR_W-1:0] rd_ptr_q;
	logic [FIFO_CNT_W-1:0] count_q;
	logic                  do_push;
	logic                  do_pop;

	// Pointers wrap explicitly so the depth need not be a power of two.
	function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
		if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_push = push_i && !full_o; // A push into a full queue is dropped.
	assign do_pop = pop_i && !empty_o;
	assign empty_o = (count_q == '0);
	assign full_o = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
	assign head_o = mem[rd_ptr_q]; // First word falls through to the output.

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr_q] <= push_data_i;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q; // Both or neither leave the level unchanged.
			endcase
		end
	end

	a_no_push_when_full: assert property (@(posedge clk) disable iff (!resetn)
		push_i |-> !full_o)
		else $error("uart_fifo: write into a full queue, entry lost");

	a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!resetn)
		pop_i |-> !empty_o)
		else $error("uart_fifo: read from an empty queue");

endmodule

//--- source/uart_rx.sv
module uart_rx (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic [uart_cfg_pkg::CPD_W-1:0] cycles_per_databit_i,
	input  logic                           rx_line_i,
	output uart_frame_pkg::uart_rx_frame_t frame_o,
	output logic                           frame_valid_o,
	output logic                           rx_busy_o
);
	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START_CHK,
		RX_WAIT,
		RX_SAMPLE,
		RX_STOP_CHK,
		RX_DONE
	} rx_state_t;

	rx_state_t            state_q;
	rx_state_t            state_d;
	logic [CPD_W-1:0]     timer_q;
	logic [CPD_W-1:0]     half_period;
	logic [CPD_W-1:0]     last_tick;
	logic [BIT_IDX_W-1:0] bit_idx_q;
	uart_rx_frame_t       frame_q;

	assign half_period = cycles_per_databit_i >> 1;
	assign last_tick = cycles_per_databit_i - CPD_W'(1); // The sample state adds the final cycle.

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			RX_IDLE:
			begin
				if (!rx_line_i)
					state_d = RX_START_CHK;
			end
			RX_START_CHK:
			begin
				// Middle of the start bit. A high line means it was only a glitch.
				if (timer_q == half_period)
					state_d = rx_line_i ? RX_IDLE : RX_WAIT;
			end
			RX_WAIT:
			begin
				if (timer_q == last_tick)
					state_d = (bit_idx_q == BIT_IDX_W'(DATA_BITS)) ? RX_STOP_CHK : RX_SAMPLE;
			end
			RX_SAMPLE: state_d = RX_WAIT;
			RX_STOP_CHK: state_d = RX_DONE;
			RX_DONE: state_d = RX_IDLE;
			default: state_d = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state_q <= RX_IDLE;
			timer_q <= '0;
			bit_idx_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (state_d != state_q)
				timer_q <= CPD_W'(1); // Every state entry restarts the count.
			else if (state_q != RX_IDLE)
				timer_q <= timer_q + 1'b1;
			if (state_q == RX_START_CHK)
				bit_idx_q <= '0;
			else if (state_q == RX_SAMPLE)
				bit_idx_q <= bit_idx_q + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state_q == RX_SAMPLE)
			frame_q.data <= {rx_line_i, frame_q.data[DATA_BITS-1:1]}; // LSB arrives first.
		if (state_q == RX_STOP_CHK)
			frame_q.frame_err <= !rx_line_i;
	end

	assign frame_o = frame_q;
	assign frame_valid_o = (state_q == RX_DONE);
	assign rx_busy_o = (state_q == RX_WAIT) || (state_q == RX_SAMPLE) ||
		(state_q == RX_STOP_CHK);

	// The half-period check and sample spacing need a few cycles to work with.
	a_min_period: assert property (@(posedge clk) disable iff (!resetn)
		rx_busy_o |-> (cycles_per_databit_i >= CPD_W'(MIN_CPD)))
		else $error("uart_rx: bit period below the supported minimum");

endmodule

//--- source/uart_tx.sv
module uart_tx (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic [uart_cfg_pkg::CPD_W-1:0] cycles_per_databit_i,
	input  uart_frame_pkg::uart_byte_t     data_i,
	input  logic                           data_avail_i,
	output logic                           take_o,
	output logic                           tx_line_o,
	output logic                           tx_busy_o
);
	import uart_cfg_pkg::*;

	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_t;

	tx_state_t              state_q;
	logic [FRAME_BITS-1:0]  shift_q;
	logic [CPD_W-1:0]       timer_q;
	logic [CPD_W-1:0]       last_tick;
	logic [FRAME_CNT_W-1:0] bit_cnt_q;
	logic                   bit_end;
	logic                   frame_end;

	assign last_tick = cycles_per_databit_i - CPD_W'(1);
	assign bit_end = (state_q == TX_SEND) && (timer_q == last_tick);
	assign frame_end = bit_end && (bit_cnt_q == FRAME_CNT_W'(FRAME_BITS - 1));

	// Popping in the last stop-bit cycle lets the next start bit follow with no gap.
	assign take_o = data_avail_i && ((state_q == TX_IDLE) || frame_end);

	assign tx_line_o = shift_q[0];
	assign tx_busy_o = (state_q == TX_SEND);

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state_q <= TX_IDLE;
			shift_q <= '1; // Line idles high.
			timer_q <= '0;
			bit_cnt_q <= '0;
		end
		else if (take_o)
		begin
			state_q <= TX_SEND;
			shift_q <= {1'b1, data_i, 1'b0}; // Stop bit, data, start bit at the bottom.
			timer_q <= '0;
			bit_cnt_q <= '0;
		end
		else if (frame_end)
		begin
			state_q <= TX_IDLE;
			shift_q <= '1;
			timer_q <= '0;
		end
		else if (bit_end)
		begin
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
			timer_q <= '0;
			bit_cnt_q <= bit_cnt_q + 1'b1;
		end
		else if (state_q == TX_SEND)
			timer_q <= timer_q + 1'b1;
	end

endmodule

//--- source/uart_top.sv
module uart_top (
	input  logic                           clk,
	input  logic                           resetn,
	input  logic [uart_cfg_pkg::CPD_W-1:0] cycles_per_databit_i,
	input  uart_frame_pkg::uart_byte_t     tx_data_i,
	input  logic                           tx_write_i,
	output logic                           tx_full_o,
	output logic                           tx_line_o,
	output logic                           tx_busy_o,
	input  logic                           rx_line_i,
	output uart_frame_pkg::uart_rx_frame_t rx_frame_o,
	output logic                           rx_empty_o,
	input  logic                           rx_read_i,
	output logic                           rx_busy_o,
	output logic                           rx_overrun_o
);
	import uart_frame_pkg::*;

	uart_byte_t     tx_head;
	logic           tx_empty;
	logic           tx_avail;
	logic           tx_take;
	uart_rx_frame_t rx_frame;
	logic           rx_frame_valid;
	logic           rx_full;
	logic           rx_push;

	uart_fifo #(.payload_t(uart_byte_t)) tx_queue (
		.clk(clk),
		.resetn(resetn),
		.push_i(tx_write_i),
		.push_data_i(tx_data_i),
		.pop_i(tx_take),
		.head_o(tx_head),
		.empty_o(tx_empty),
		.full_o(tx_full_o)
	);

	assign tx_avail = !tx_empty;

	uart_tx u_tx (
		.clk(clk),
		.resetn(resetn),
		.cycles_per_databit_i(cycles_per_databit_i),
		.data_i(tx_head),
		.data_avail_i(tx_avail),
		.take_o(tx_take),
		.tx_line_o(tx_line_o),
		.tx_busy_o(tx_busy_o)
	);

	uart_rx u_rx (
		.clk(clk),
		.resetn(resetn),
		.cycles_per_databit_i(cycles_per_databit_i),
		.rx_line_i(rx_line_i),
		.frame_o(rx_frame),
		.frame_valid_o(rx_frame_valid),
		.rx_busy_o(rx_busy_o)
	);

	// The serial line cannot be held off, so a frame with no room is dropped.
	assign rx_push = rx_frame_valid && !rx_full;
	assign rx_overrun_o = rx_frame_valid && rx_full;

	uart_fifo #(.payload_t(uart_rx_frame_t)) rx_queue (
		.clk(clk),
		.resetn(resetn),
		.push_i(rx_push),
		.push_data_i(rx_frame),
		.pop_i(rx_read_i),
		.head_o(rx_frame_o),
		.empty_o(rx_empty_o),
		.full_o(rx_full)
	);

endmodule

//--- tb/uart_tb.sv
module uart_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import uart_cfg_pkg::*;
	import uart_frame_pkg::*;

	localparam int P_LOOP = 8;
	localparam int P_DRIVEN = 11;
	localparam int N_LOOP = 40;
	localparam int N_DRIVEN = 12;
	localparam int N_OVR = 6;
	localparam int TIMEOUT_CYCLES = (N_LOOP + N_DRIVEN + N_OVR) * 10 * P_DRIVEN * 2 + 2000;

	logic             clk;
	logic             resetn;
	logic [CPD_W-1:0] cpd;
	uart_byte_t       tx_data;
	logic             tx_write;
	logic             tx_full;
	logic             tx_line;
	logic             tx_busy;
	logic             rx_line;
	uart_rx_frame_t   rx_frame;
	logic             rx_empty;
	logic             rx_read;
	logic             rx_busy;
	logic             rx_overrun;
	logic             drv_line;
	logic             loopback;
	logic             read_en;
	int               val_err = 0;
	int               oth_err = 0;
	int               overrun_cnt = 0;
	int               cycle_cnt = 0;
	uart_rx_frame_t   exp_q[$]; // Frames the receive queue should deliver, oldest first.

	uart_top UUT (
		.clk(clk),
		.resetn(resetn),
		.cycles_per_databit_i(cpd),
		.tx_data_i(tx_data),
		.tx_write_i(tx_write),
		.tx_full_o(tx_full),
		.tx_line_o(tx_line),
		.tx_busy_o(tx_busy),
		.rx_line_i(rx_line),
		.rx_frame_o(rx_frame),
		.rx_empty_o(rx_empty),
		.rx_read_i(rx_read),
		.rx_busy_o(rx_busy),
		.rx_overrun_o(rx_overrun)
	);

	assign rx_line = loopback ? tx_line : drv_line; // Loopback or frames shaped by the driver.

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic void count_mismatch(input string msg);
		val_err++;
		$display("error at %0t ns: %s", $time, msg);
	endfunction

	function automatic void report_failure(input string msg);
		oth_err++;
		$display("%s", msg);
	endfunction

	// Reader pops every frame the queue offers and compares it with the model.
	initial
	begin
		uart_rx_frame_t exp;
		rx_read = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			rx_read = 1'b0;
			if (rx_overrun)
				overrun_cnt++;
			if (resetn && read_en && !rx_empty)
			begin
				assert (exp_q.size() > 0)
				else report_failure($sformatf("Frame %h arrived with none expected", rx_frame));
				if (exp_q.size() > 0)
				begin
					exp = exp_q.pop_front();
					assert (rx_frame == exp)
					else count_mismatch($sformatf("frame %h, expected %h", rx_frame, exp));
				end
				rx_read = 1'b1;
			end
		end
	end

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#1; // Inputs change just after the edge.
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0 || tx_busy || rx_busy)
			idle_cycles(1);
		idle_cycles(4);
	endtask

	// Shapes one frame on the line at the driven bit period.
	task automatic send_frame(input uart_byte_t data, input logic stop_bit);
		int i;
		drv_line = 1'b0;
		idle_cycles(P_DRIVEN);
		for (i = 0; i < DATA_BITS; i++)
		begin
			drv_line = data[i];
			idle_cycles(P_DRIVEN);
		end
		drv_line = stop_bit;
		idle_cycles(P_DRIVEN);
		drv_line = 1'b1;
		idle_cycles(2 * P_DRIVEN); // Lets the receiver settle back in idle.
	endtask

	task automatic expect_frame(input uart_byte_t data, input logic stop_bit);
		uart_rx_frame_t exp;
		exp.data = data;
		exp.frame_err = !stop_bit;
		exp_q.push_back(exp);
	endtask

	task automatic check_reset_state();
		assert (tx_line === 1'b1) else count_mismatch("tx_line_o not high after reset");
		assert (tx_busy === 1'b0) else count_mismatch("tx_busy_o not low after reset");
		assert (rx_busy === 1'b0) else count_mismatch("rx_busy_o not low after reset");
		assert (rx_overrun === 1'b0) else count_mismatch("rx_overrun_o not low after reset");
		assert (tx_full === 1'b0) else count_mismatch("tx_full_o not low after reset");
		assert (rx_empty === 1'b1) else count_mismatch("rx_empty_o not high after reset");
	endtask

	// Writes whenever there is room, so the transmit queue fills up.
	task automatic loopback_burst();
		int n;
		bit saw_full;
		bit saw_release;
		n = 0;
		saw_full = 1'b0;
		saw_release = 1'b0;
		while (n < N_LOOP)
		begin
			tx_write = 1'b0;
			if (tx_full)
				saw_full = 1'b1;
			else
			begin
				saw_release = saw_full;
				tx_data = uart_byte_t'($urandom());
				tx_write = 1'b1;
				expect_frame(tx_data, 1'b1);
				n++;
			end
			idle_cycles(1);
		end
		tx_write = 1'b0;
		wait_drained();
		assert (saw_full) else report_failure("Transmit queue never reported full");
		assert (saw_release) else report_failure("Transmit queue never left the full state");
	endtask

	task automatic stop_bit_frames();
		uart_byte_t data;
		logic stop_bit;
		for (int i = 0; i < N_DRIVEN; i++)
		begin
			data = uart_byte_t'($urandom());
			stop_bit = (i == 0) ? 1'b0 : 1'($urandom()); // At least one bad stop bit.
			expect_frame(data, stop_bit);
			send_frame(data, stop_bit);
		end
		wait_drained();
	endtask

	task automatic glitch_check();
		drv_line = 1'b0;
		idle_cycles(P_DRIVEN / 2 - 2);
		drv_line = 1'b1;
		repeat (3 * P_DRIVEN)
		begin
			assert (rx_empty && !rx_busy && exp_q.size() == 0)
			else report_failure("A short low glitch was taken as a frame");
			idle_cycles(1);
		end
	endtask

	// Reading is held off, so frames beyond the queue depth are dropped.
	task automatic overrun_check();
		uart_byte_t data;
		read_en = 1'b0;
		overrun_cnt = 0;
		for (int i = 0; i < N_OVR; i++)
		begin
			data = uart_byte_t'($urandom());
			if (i < FIFO_DEPTH)
				expect_frame(data, 1'b1);
			send_frame(data, 1'b1);
		end
		assert (overrun_cnt == N_OVR - FIFO_DEPTH)
		else count_mismatch($sformatf("%0d overrun pulses, expected %0d", overrun_cnt,
			N_OVR - FIFO_DEPTH));
		read_en = 1'b1;
		wait_drained();
		idle_cycles(10);
		assert (rx_empty) else report_failure("Receive queue still holds frames after the drain");
	endtask

	initial
	begin
		void'($urandom(32'h33de4316));
		resetn = 1'b0;
		cpd = CPD_W'(P_LOOP);
		tx_data = '0;
		tx_write = 1'b0;
		drv_line = 1'b1;
		loopback = 1'b1;
		read_en = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		resetn = 1'b1;
		check_reset_state();
		idle_cycles(2);
		loopback_burst();
		loopback = 1'b0; // Both lines idle high here, so the switch is clean.
		cpd = CPD_W'(P_DRIVEN);
		idle_cycles(2);
		stop_bit_frames();
		glitch_check();
		overrun_check();
		$display("Errors: %0d wrong values, %0d other failures", val_err, oth_err);
		if (val_err == 0 && oth_err == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- vlog.f
source/uart_cfg_pkg.sv
source/uart_frame_pkg.sv
source/uart_fifo.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_top.sv
tb/uart_tb.sv

//--- Makefile
.PHONY: sim clean

# The run passes only if the testbench printed its pass line.
sim:
	verilator --binary --timing --assert --top-module uart_tb -f vlog.f -o uart_sim
	./obj_dir/uart_sim | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
